/* Bender.yml */
package:
  name: mini_pipe

sources:
  - files:
      - rtl/isaPkg.sv
      - rtl/pipePkg.sv
      - rtl/hazardIf.sv
      - rtl/hazardUnit.sv
      - rtl/regFile.sv
      - rtl/execUnit.sv
      - rtl/miniPipe.sv
  - target: simulation
    files:
      - dv/miniPipeTb.sv

/* dv/miniPipeTb.sv */
`timescale 1ns/10ps
`default_nettype none

module miniPipeTb;

    typedef enum logic [2:0] {
        TAdd,
        TSub,
        TAddi,
        TLd,
        TMul
    } kindT;

    // the memory answers every load with its address mixed with this pattern.
    localparam isaPkg::wordT LdPattern = 64'h5a5a_0f0f_c3c3_9696;
    // tests issue 6, 12, 10, 10, 6 and 40 instructions.
    localparam int NumInst = 84;
    localparam int CycleLimit = 40 * NumInst;

    logic clk = 1'b0;
    logic rstN;
    logic instValid;
    logic instReady;
    isaPkg::instWordT instWord;
    logic ldValid;
    isaPkg::wordT ldAddr;
    logic ldReady;
    isaPkg::wordT ldData;
    logic retireValid;
    isaPkg::regAddrT retireRd;
    isaPkg::wordT retireData;

    isaPkg::wordT refRegs [32];
    isaPkg::regAddrT expRd [$];
    isaPkg::wordT expData [$];
    int errCount = 0;
    int checkCount = 0;
    int cycles = 0;
    int lastStalls = 0;
    int seedDummy;

    logic reqActive = 1'b0;
    int reqDelay = 0;
    isaPkg::wordT reqAddr;

    miniPipe #(
        .MulLatency(4)
    ) miniPipe_inst (
        .clk(clk),
        .rstN(rstN),
        .instValid(instValid),
        .instReady(instReady),
        .instWord(instWord),
        .ldValid(ldValid),
        .ldAddr(ldAddr),
        .ldReady(ldReady),
        .ldData(ldData),
        .retireValid(retireValid),
        .retireRd(retireRd),
        .retireData(retireData)
    );

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
        end
    endtask

    function automatic isaPkg::instWordT encode(input kindT kind, input isaPkg::regAddrT rd,
                                                input isaPkg::regAddrT rs1,
                                                input isaPkg::regAddrT rs2,
                                                input logic [11:0] imm);
        isaPkg::instWordT w;
        case (kind)
            TAdd: w = {isaPkg::F7Add, rs2, rs1, isaPkg::F3AddSub, rd, isaPkg::OpReg};
            TSub: w = {isaPkg::F7Sub, rs2, rs1, isaPkg::F3AddSub, rd, isaPkg::OpReg};
            TMul: w = {isaPkg::F7Mul, rs2, rs1, isaPkg::F3AddSub, rd, isaPkg::OpReg};
            TAddi: w = {imm, rs1, isaPkg::F3AddSub, rd, isaPkg::OpImm};
            default: w = {imm, rs1, isaPkg::F3Ld, rd, isaPkg::OpLoad};
        endcase
        return w;
    endfunction

    // reference model, runs in program order as each instruction is accepted.
    task automatic predict(input kindT kind, input isaPkg::regAddrT rd,
                           input isaPkg::regAddrT rs1, input isaPkg::regAddrT rs2,
                           input logic [11:0] imm);
        isaPkg::wordT a;
        isaPkg::wordT b;
        isaPkg::wordT immX;
        isaPkg::wordT res;
        a = refRegs[rs1];
        b = refRegs[rs2];
        immX = {{52{imm[11]}}, imm};
        case (kind)
            TAdd: res = a + b;
            TSub: res = a - b;
            TMul: res = a * b;
            TAddi: res = a + immX;
            default: res = (a + immX) ^ LdPattern;
        endcase
        if (rd == '0) begin
            res = '0;
        end else begin
            refRegs[rd] = res;
        end
        expRd.push_back(rd);
        expData.push_back(res);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic issue(input kindT kind, input int rd, input int rs1, input int rs2,
                         input int imm, input int gap);
        int stalls;
        stalls = 0;
        if (gap > 0) begin
            instValid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        instWord = encode(kind, rd[4:0], rs1[4:0], rs2[4:0], imm[11:0]);
        instValid = 1'b1;
        #1;
        while (!instReady) begin
            stalls++;
            @(negedge clk);
            #1;
        end
        predict(kind, rd[4:0], rs1[4:0], rs2[4:0], imm[11:0]);
        lastStalls = stalls;
        @(negedge clk);
    endtask

    task automatic drain();
        instValid = 1'b0;
        while (expRd.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        $display("%s: done, %0d errors", name, errCount - errBefore);
    endtask

    task automatic independentOps();
        int errBefore;
        errBefore = errCount;
        issue(TAddi, 1, 0, 0, 5, 0);
        issue(TAddi, 2, 0, 0, -3, 0);
        issue(TAddi, 3, 0, 0, 2047, 0);
        issue(TAddi, 5, 0, 0, -2048, 0);
        drain();
        issue(TAdd, 6, 1, 2, 0, 0);
        issue(TSub, 7, 3, 5, 0, 0);
        drain();
        finishTest("independent ops", errBefore);
    endtask

    task automatic dependentChains();
        int errBefore;
        errBefore = errCount;
        issue(TAddi, 8, 1, 0, 1, 0);
        issue(TAdd, 9, 8, 8, 0, 0);
        issue(TAddi, 10, 0, 0, 7, 0);
        issue(TAddi, 11, 0, 0, 9, 0);
        issue(TSub, 12, 10, 3, 0, 0);
        issue(TAddi, 13, 0, 0, 20, 0);
        issue(TAddi, 14, 0, 0, 1, 0);
        issue(TAddi, 15, 0, 0, 2, 0);
        issue(TAdd, 16, 13, 14, 0, 0);
        issue(TAddi, 17, 16, 0, 1, 0);
        issue(TAddi, 17, 17, 0, 1, 0);
        issue(TAddi, 17, 17, 0, 1, 0);
        drain();
        finishTest("dependent chains", errBefore);
    endtask

    task automatic loadUse();
        int errBefore;
        errBefore = errCount;
        issue(TAddi, 20, 0, 0, 256, 0);
        issue(TLd, 21, 20, 0, 8, 0);
        issue(TAdd, 22, 21, 21, 0, 0);
        issue(TLd, 23, 20, 0, -16, 0);
        issue(TAdd, 24, 23, 1, 0, 0);
        issue(TSub, 25, 24, 23, 0, 0);
        issue(TLd, 26, 21, 0, 0, 0);
        issue(TLd, 27, 20, 0, 0, 0);
        issue(TLd, 28, 20, 0, 4, 0);
        issue(TAdd, 29, 27, 28, 0, 0);
        drain();
        finishTest("load use", errBefore);
    endtask

    task automatic mulChain();
        int errBefore;
        int waits;
        errBefore = errCount;
        issue(TMul, 6, 1, 2, 0, 0);
        issue(TMul, 7, 6, 6, 0, 0);
        issue(TMul, 8, 7, 1, 0, 0);
        issue(TLd, 9, 0, 0, 32, 0);
        issue(TMul, 10, 9, 9, 0, 0);
        issue(TAdd, 11, 10, 9, 0, 0);
        issue(TAddi, 12, 0, 0, -1, 0);
        drain();
        // nothing pending, so any wait below comes from the busy multiplier.
        issue(TMul, 13, 12, 10, 0, 0);
        issue(TAddi, 14, 0, 0, 3, 0);
        waits = lastStalls;
        issue(TAddi, 15, 0, 0, 4, 0);
        waits += lastStalls;
        if (waits == 0) begin
            errCount++;
            $display("instReady stayed high while the multiply was busy");
        end
        drain();
        finishTest("mul chain", errBefore);
    endtask

    task automatic zeroReg();
        int errBefore;
        errBefore = errCount;
        issue(TAddi, 0, 0, 0, 55, 0);
        issue(TAdd, 0, 1, 2, 0, 0);
        issue(TLd, 0, 20, 0, 0, 0);
        issue(TAdd, 18, 0, 0, 0, 0);
        issue(TAddi, 0, 1, 0, 9, 0);
        issue(TAdd, 19, 0, 1, 0, 0);
        drain();
        finishTest("x0 writes", errBefore);
    endtask

    task automatic randomMix();
        int errBefore;
        kindT kind;
        int gap;
        errBefore = errCount;
        for (int n = 0; n < 40; n++) begin
            kind = kindT'(3'($urandom % 5));
            gap = ($urandom % 3 == 0) ? 1 + int'($urandom % 3) : 0;
            issue(kind, $urandom % 32, $urandom % 32, $urandom % 32, $urandom % 4096, gap);
        end
        drain();
        finishTest("random mix", errBefore);
    endtask

    // memory model with a random 0 to 3 cycle delay per request.
    always @(negedge clk) begin
        if (rstN) begin
            if (ldReady) begin
                ldReady = 1'b0;
                reqActive = 1'b0;
            end
            if (ldValid) begin
                if (!reqActive) begin
                    reqActive = 1'b1;
                    reqAddr = ldAddr;
                    reqDelay = $urandom % 4;
                end else begin
                    check("ldAddr", ldAddr, reqAddr);
                end
                if (reqDelay == 0) begin
                    ldReady = 1'b1;
                    ldData = ldAddr ^ LdPattern;
                end else begin
                    reqDelay--;
                end
            end else if (reqActive) begin
                errCount++;
                $display("ldValid dropped at %0t before the load was accepted", $time);
                reqActive = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rstN && retireValid) begin
            if (expRd.size() == 0) begin
                errCount++;
                $display("x%0d retired at %0t with no instruction outstanding", retireRd, $time);
            end else begin
                check("retireRd", 64'(retireRd), 64'(expRd.pop_front()));
                check("retireData", retireData, expData.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CycleLimit) begin
            $display("timeout, the run went past %0d cycles", CycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seedDummy = $urandom(50);
        rstN = 1'b0;
        instValid = 1'b0;
        instWord = '0;
        ldReady = 1'b0;
        ldData = '0;
        foreach (refRegs[i]) begin
            refRegs[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        independentOps();
        dependentChains();
        loadUse();
        mulChain();
        zeroReg();
        randomMix();
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module execUnit #(
    parameter int MulLatency = 4
) (
    input logic clk,
    input logic rstN,
    input logic start,
    input pipePkg::aluOpT aluOp,
    input isaPkg::wordT opA,
    input isaPkg::wordT opB,
    output isaPkg::wordT result,
    output logic busy
);

    // busy covers the entry cycle plus RunCycles more.
    localparam int RunCycles = (MulLatency > 1) ? MulLatency - 2 : 0;
    localparam int CntW = $clog2(MulLatency + 1);

    logic [CntW-1:0] cnt;
    isaPkg::wordT product;

    assign busy = (start && (MulLatency > 1)) || (cnt != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CntW'(RunCycles);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    generate
        if (MulLatency == 1) begin : gCombMul
            assign product = opA * opB;
        end else begin : gIterMul
            // shift-add over MulLatency-1 steps, one multiplier digit per step.
            localparam int StepBits = (62 + MulLatency) / (MulLatency - 1);

            isaPkg::wordT acc, mcand, mplier;

            always_ff @(posedge clk) begin
                if (start) begin
                    acc <= opA * isaPkg::wordT'(opB[StepBits-1:0]);
                    mcand <= opA << StepBits;
                    mplier <= opB >> StepBits;
                end else if (cnt != '0) begin
                    acc <= acc + mcand * isaPkg::wordT'(mplier[StepBits-1:0]);
                    mcand <= mcand << StepBits;
                    mplier <= mplier >> StepBits;
                end
            end

            assign product = acc;
        end
    endgenerate

    always_comb begin
        case (aluOp)
            pipePkg::Sub: result = opA - opB;
            pipePkg::Mul: result = product;
            default: result = opA + opB;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/hazardIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface hazardIf;

    // sources, destinations and wait flags from the pipeline.
    isaPkg::regAddrT rs1D;
    isaPkg::regAddrT rs2D;
    isaPkg::regAddrT rs1E;
    isaPkg::regAddrT rs2E;
    isaPkg::regAddrT dstE;
    isaPkg::regAddrT dstM;
    isaPkg::regAddrT dstM2;
    isaPkg::regAddrT dstW;
    logic wrE, wrM, wrM2, wrW;
    logic loadE, loadM;
    logic mulD;
    logic eWait, dWait, iWait;

    // decisions back to the pipeline.
    logic stallF, stallD, stallE, stallM;
    logic flushD, flushE, flushM, flushM2;
    pipePkg::fwdSelT fwdAD, fwdBD, fwdAE, fwdBE;

    modport pipe (
        output rs1D, rs2D, rs1E, rs2E, dstE, dstM, dstM2, dstW,
        output wrE, wrM, wrM2, wrW, loadE, loadM, mulD,
        output eWait, dWait, iWait,
        input stallF, stallD, stallE, stallM,
        input flushD, flushE, flushM, flushM2,
        input fwdAD, fwdBD, fwdAE, fwdBE
    );

    modport hazard (
        input rs1D, rs2D, rs1E, rs2E, dstE, dstM, dstM2, dstW,
        input wrE, wrM, wrM2, wrW, loadE, loadM, mulD,
        input eWait, dWait, iWait,
        output stallF, stallD, stallE, stallM,
        output flushD, flushE, flushM, flushM2,
        output fwdAD, fwdBD, fwdAE, fwdBE
    );

endinterface

`default_nettype wire

/* rtl/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    hazardIf.hazard hz
);

    logic loadUse;
    logic mulStall;
    logic dataHazard;

    function automatic logic readsReg(isaPkg::regAddrT dst);
        return (hz.rs1D == dst) || (hz.rs2D == dst);
    endfunction

    function automatic logic readsNonZero(isaPkg::regAddrT dst);
        return (hz.rs1D != '0 && hz.rs1D == dst) || (hz.rs2D != '0 && hz.rs2D == dst);
    endfunction

    // youngest producer wins; x0 is never forwarded.
    function automatic pipePkg::fwdSelT pickFwd(isaPkg::regAddrT src);
        pipePkg::fwdSelT sel;
        sel = pipePkg::FwdNone;
        if (src != '0) begin
            if (hz.wrM && src == hz.dstM) begin
                sel = pipePkg::FwdM;
            end else if (hz.wrM2 && src == hz.dstM2) begin
                sel = pipePkg::FwdM2;
            end else if (hz.wrW && src == hz.dstW) begin
                sel = pipePkg::FwdW;
            end
        end
        return sel;
    endfunction

    always_comb begin
        // load data only shows up in M2.
        loadUse = (hz.loadE && readsReg(hz.dstE)) || (hz.loadM && readsReg(hz.dstM));
        // a multiply latches its operands on entry, so every producer must have left M2.
        mulStall = hz.mulD && ((hz.wrE && readsReg(hz.dstE))
                               || (hz.wrM && readsNonZero(hz.dstM))
                               || (hz.wrM2 && readsNonZero(hz.dstM2)));
    end

    assign dataHazard = loadUse || mulStall;

    always_comb begin
        hz.stallF = 1'b0;
        hz.stallD = 1'b0;
        hz.stallE = 1'b0;
        hz.stallM = 1'b0;
        hz.flushD = 1'b0;
        hz.flushE = 1'b0;
        hz.flushM = 1'b0;
        hz.flushM2 = 1'b0;
        if (hz.eWait) begin
            hz.stallF = 1'b1;
            hz.stallD = 1'b1;
            hz.stallE = 1'b1;
            if (hz.dWait) begin
                // the waiting load stays in M and must not be copied on.
                hz.stallM = 1'b1;
                hz.flushM2 = 1'b1;
            end else begin
                hz.flushM = 1'b1;
            end
        end else if (hz.dWait) begin
            hz.stallF = 1'b1;
            hz.stallD = 1'b1;
            hz.stallE = 1'b1;
            hz.stallM = 1'b1;
            hz.flushM2 = 1'b1;
        end else if (dataHazard) begin
            hz.stallF = 1'b1;
            hz.stallD = 1'b1;
            hz.flushE = 1'b1;
        end else if (hz.iWait) begin
            hz.flushD = 1'b1;
        end
    end

    always_comb begin
        hz.fwdAD = pickFwd(hz.rs1D);
        hz.fwdBD = pickFwd(hz.rs2D);
        // a busy multiplier works from its own copy of the operands.
        hz.fwdAE = hz.eWait ? pipePkg::FwdNone : pickFwd(hz.rs1E);
        hz.fwdBE = hz.eWait ? pipePkg::FwdNone : pickFwd(hz.rs2E);
    end

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef logic [4:0] regAddrT;
    typedef logic [63:0] wordT;
    typedef logic [6:0] opcodeT;

    // major opcodes.
    localparam opcodeT OpReg = 7'b0110011;
    localparam opcodeT OpImm = 7'b0010011;
    localparam opcodeT OpLoad = 7'b0000011;

    // add, sub, mul and addi all share funct3 zero.
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Ld = 3'b011;

    localparam logic [6:0] F7Add = 7'b0000000;
    localparam logic [6:0] F7Sub = 7'b0100000;
    localparam logic [6:0] F7Mul = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        regAddrT rs2;
        regAddrT rs1;
        logic [2:0] funct3;
        regAddrT rd;
        opcodeT opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;
        regAddrT rs1;
        logic [2:0] funct3;
        regAddrT rd;
        opcodeT opcode;
    } iTypeT;

    // one instruction word, read as register-register or as immediate form.
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instWordT;

endpackage

`default_nettype wire

/* rtl/miniPipe.sv */
`timescale 1ns/10ps
`default_nettype none

module miniPipe #(
    parameter int MulLatency = 4
) (
    input logic clk,
    input logic rstN,
    input logic instValid,
    output logic instReady,
    input isaPkg::instWordT instWord,
    output logic ldValid,
    output isaPkg::wordT ldAddr,
    input logic ldReady,
    input isaPkg::wordT ldData,
    output logic retireValid,
    output isaPkg::regAddrT retireRd,
    output isaPkg::wordT retireData
);

    hazardIf hz ();

    logic running, dValid, dUseImm, eFresh, exBusy, wEn;
    isaPkg::instWordT dInst;
    isaPkg::regAddrT dRs1, dRs2, eRs1, eRs2;
    pipePkg::ctrlT dCtrl, eCtrl, mCtrl, m2Ctrl, wCtrl;
    isaPkg::wordT dImm, rfA, rfB, dOpA, dOpB, eOpA, eOpB, aluA, aluB, exResult;
    isaPkg::wordT mResult, m2Result, wResult;

    function automatic isaPkg::wordT pickOperand(pipePkg::fwdSelT sel, isaPkg::wordT regVal);
        case (sel)
            pipePkg::FwdM: return mResult;
            pipePkg::FwdM2: return m2Result;
            pipePkg::FwdW: return wResult;
            default: return regVal;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign instReady = running && !hz.stallF;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dValid <= 1'b0;
        end else if (hz.flushD) begin
            dValid <= 1'b0;
        end else if (!hz.stallD) begin
            dValid <= instValid && instReady;
        end
    end

    always_ff @(posedge clk) begin
        if (instValid && instReady) begin
            dInst <= instWord;
        end
    end

    // decode, reading the word through whichever view fits the opcode.
    always_comb begin
        dCtrl = pipePkg::CtrlNone;
        dUseImm = 1'b0;
        dRs1 = '0;
        dRs2 = '0;
        dImm = {{52{dInst.i.imm12[11]}}, dInst.i.imm12};
        case (dInst.r.opcode)
            isaPkg::OpReg: begin
                dRs1 = dInst.r.rs1;
                dRs2 = dInst.r.rs2;
                dCtrl.rd = dInst.r.rd;
                dCtrl.regWrite = (dInst.r.funct3 == isaPkg::F3AddSub);
                case (dInst.r.funct7)
                    isaPkg::F7Add: dCtrl.aluOp = pipePkg::Add;
                    isaPkg::F7Sub: dCtrl.aluOp = pipePkg::Sub;
                    isaPkg::F7Mul: begin
                        dCtrl.aluOp = pipePkg::Mul;
                        dCtrl.isMul = dCtrl.regWrite;
                    end
                    default: dCtrl.regWrite = 1'b0;
                endcase
            end
            isaPkg::OpImm, isaPkg::OpLoad: begin
                dRs1 = dInst.i.rs1;
                dCtrl.rd = dInst.i.rd;
                dUseImm = 1'b1;
                if (dInst.i.opcode == isaPkg::OpLoad) begin
                    dCtrl.regWrite = (dInst.i.funct3 == isaPkg::F3Ld);
                    dCtrl.isLoad = dCtrl.regWrite;
                end else begin
                    dCtrl.regWrite = (dInst.i.funct3 == isaPkg::F3AddSub);
                end
            end
            default: dCtrl.regWrite = 1'b0;
        endcase
        dCtrl.valid = 1'b1;
        if (!dValid) begin
            dCtrl = pipePkg::CtrlNone;
            dRs1 = '0;
            dRs2 = '0;
        end
    end

    always_comb begin
        dOpA = pickOperand(hz.fwdAD, rfA);
        dOpB = dUseImm ? dImm : pickOperand(hz.fwdBD, rfB);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            eCtrl <= pipePkg::CtrlNone;
            eFresh <= 1'b0;
        end else if (hz.stallE) begin
            eFresh <= 1'b0;
        end else if (hz.flushE) begin
            eCtrl <= pipePkg::CtrlNone;
            eFresh <= 1'b0;
        end else begin
            eCtrl <= dCtrl;
            eFresh <= dCtrl.valid;
        end
    end

    // a stalled E keeps whatever was forwarded, its producer may retire meanwhile.
    always_ff @(posedge clk) begin
        if (hz.stallE) begin
            eOpA <= aluA;
            eOpB <= aluB;
        end else if (!hz.flushE) begin
            eOpA <= dOpA;
            eOpB <= dOpB;
            eRs1 <= dRs1;
            eRs2 <= dRs2;
        end
    end

    always_comb begin
        aluA = pickOperand(hz.fwdAE, eOpA);
        aluB = pickOperand(hz.fwdBE, eOpB);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mCtrl <= pipePkg::CtrlNone;
            m2Ctrl <= pipePkg::CtrlNone;
            wCtrl <= pipePkg::CtrlNone;
        end else begin
            if (hz.flushM) begin
                mCtrl <= pipePkg::CtrlNone;
            end else if (!hz.stallM) begin
                mCtrl <= eCtrl;
            end
            m2Ctrl <= hz.flushM2 ? pipePkg::CtrlNone : mCtrl;
            wCtrl <= m2Ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stallM) begin
            mResult <= exResult;
        end
        m2Result <= mCtrl.isLoad ? ldData : mResult;
        wResult <= m2Result;
    end

    assign ldValid = mCtrl.valid && mCtrl.isLoad;
    assign ldAddr = mResult;
    assign wEn = wCtrl.valid && wCtrl.regWrite;
    assign retireValid = wCtrl.valid;
    assign retireRd = wCtrl.rd;
    assign retireData = (wEn && wCtrl.rd != '0) ? wResult : '0;

    assign hz.rs1D = dRs1;
    assign hz.rs2D = dRs2;
    assign hz.rs1E = eCtrl.valid ? eRs1 : '0;
    assign hz.rs2E = eCtrl.valid ? eRs2 : '0;
    assign hz.dstE = eCtrl.rd;
    assign hz.dstM = mCtrl.rd;
    assign hz.dstM2 = m2Ctrl.rd;
    assign hz.dstW = wCtrl.rd;
    assign hz.wrE = eCtrl.valid && eCtrl.regWrite;
    assign hz.wrM = mCtrl.valid && mCtrl.regWrite;
    assign hz.wrM2 = m2Ctrl.valid && m2Ctrl.regWrite;
    assign hz.wrW = wEn;
    assign hz.loadE = eCtrl.valid && eCtrl.isLoad;
    assign hz.loadM = ldValid;
    assign hz.mulD = dCtrl.isMul;
    assign hz.eWait = exBusy;
    assign hz.dWait = ldValid && !ldReady;
    assign hz.iWait = !instValid;

    hazardUnit hazardUnit_inst (
        .hz(hz.hazard)
    );

    regFile regFile_inst (
        .clk(clk),
        .rstN(rstN),
        .rAddrA(dRs1),
        .rAddrB(dRs2),
        .rDataA(rfA),
        .rDataB(rfB),
        .wEn(wEn),
        .wAddr(wCtrl.rd),
        .wData(wResult)
    );

    execUnit #(
        .MulLatency(MulLatency)
    ) execUnit_inst (
        .clk(clk),
        .rstN(rstN),
        .start(eFresh && eCtrl.isMul),
        .aluOp(eCtrl.aluOp),
        .opA(aluA),
        .opB(aluB),
        .result(exResult),
        .busy(exBusy)
    );

endmodule

`default_nettype wire

/* rtl/pipePkg.sv */
`default_nettype none

package pipePkg;

    // operand source, codes follow the older forwarding encoding.
    typedef enum logic [1:0] {
        FwdNone = 2'b00,
        FwdW = 2'b01,
        FwdM = 2'b10,
        FwdM2 = 2'b11
    } fwdSelT;

    typedef enum logic [1:0] {
        Add = 2'b00,
        Sub = 2'b01,
        Mul = 2'b10
    } aluOpT;

    // control word that rides along with each instruction.
    typedef struct packed {
        logic valid;
        logic regWrite;
        logic isLoad;
        logic isMul;
        aluOpT aluOp;
        isaPkg::regAddrT rd;
    } ctrlT;

    localparam ctrlT CtrlNone = '0;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input logic clk,
    input logic rstN,
    input isaPkg::regAddrT rAddrA,
    input isaPkg::regAddrT rAddrB,
    output isaPkg::wordT rDataA,
    output isaPkg::wordT rDataB,
    input logic wEn,
    input isaPkg::regAddrT wAddr,
    input isaPkg::wordT wData
);

    isaPkg::wordT regs [32];

    // x0 reads zero, a same-cycle write shows through.
    function automatic isaPkg::wordT readPort(isaPkg::regAddrT addr);
        isaPkg::wordT data;
        if (addr == '0) begin
            data = '0;
        end else if (wEn && wAddr == addr) begin
            data = wData;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wEn && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    always_comb begin
        rDataA = readPort(rAddrA);
        rDataB = readPort(rAddrB);
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/hazardIf.sv
rtl/hazardUnit.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/miniPipe.sv
dv/miniPipeTb.sv
